/* hw/pwc_pkg.sv */
package pwc_pkg;

    // phase counter width, enough for the longest symbol phase.
    localparam int DEF_CNT_WIDTH = 6;

    // high cycles after the trailing low pulse that close a frame.
    localparam int DEF_IDLE_LIMIT = 16;

    // data bits per frame, parity comes on top.
    localparam int DEF_DATA_BITS = 8;

    // decoder phases.
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LOW  = 2'd1,
        ST_HIGH = 2'd2
    } dec_state_t;

endpackage

/* hw/pwc_bit_decoder.sv */
`timescale 1ns/1ps

module pwc_bit_decoder #(
    parameter int CNT_WIDTH  = pwc_pkg::DEF_CNT_WIDTH,
    parameter int IDLE_LIMIT = pwc_pkg::DEF_IDLE_LIMIT
) (
    input  logic sample_clk,
    input  logic rst_n,
    input  logic rx_line,
    output logic bit_valid,
    output logic bit_value,
    output logic frame_end
);
    import pwc_pkg::*;

    localparam logic [CNT_WIDTH-1:0] CNT_MAX  = '1;
    localparam logic [CNT_WIDTH-1:0] CNT_ONE  = CNT_WIDTH'(1);
    localparam logic [CNT_WIDTH-1:0] IDLE_CNT = CNT_WIDTH'(IDLE_LIMIT);

    logic                 sync_q1;
    logic                 sync_q2;
    dec_state_t           state;
    logic [CNT_WIDTH-1:0] low_cnt;
    logic [CNT_WIDTH-1:0] high_cnt;
    logic [CNT_WIDTH-1:0] low_latch;
    logic                 bit_zero;

    // two flops, line idles high.
    always_ff @(posedge sample_clk) begin
        if (!rst_n) begin
            sync_q1 <= 1'b1;
            sync_q2 <= 1'b1;
        end else begin
            sync_q1 <= rx_line;
            sync_q2 <= sync_q1;
        end
    end

    // longer low phase means 0, a tie is 1.
    assign bit_zero = low_latch > high_cnt;

    always_ff @(posedge sample_clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            low_cnt   <= '0;
            high_cnt  <= '0;
            low_latch <= '0;
            bit_valid <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            bit_valid <= 1'b0;
            frame_end <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // high runs here are not counted.
                    if (!sync_q2) begin
                        low_cnt <= CNT_ONE;
                        state   <= ST_LOW;
                    end
                end
                ST_LOW: begin
                    if (sync_q2) begin
                        low_latch <= low_cnt;
                        high_cnt  <= CNT_ONE;
                        state     <= ST_HIGH;
                    end else if (low_cnt != CNT_MAX) begin
                        low_cnt <= low_cnt + 1'b1;
                    end
                end
                ST_HIGH: begin
                    if (!sync_q2) begin
                        // falling edge settles the previous symbol.
                        bit_valid <= 1'b1;
                        low_cnt   <= CNT_ONE;
                        state     <= ST_LOW;
                    end else if (high_cnt >= IDLE_CNT) begin
                        frame_end <= 1'b1;
                        low_cnt   <= '0;
                        high_cnt  <= '0;
                        low_latch <= '0;
                        state     <= ST_IDLE;
                    end else if (high_cnt != CNT_MAX) begin
                        high_cnt <= high_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge sample_clk) begin
        if (state == ST_HIGH && !sync_q2) begin
            bit_value <= !bit_zero;
        end
    end

endmodule

/* hw/pwc_frame_assembler.sv */
`timescale 1ns/1ps

module pwc_frame_assembler #(
    parameter int DATA_BITS = pwc_pkg::DEF_DATA_BITS
) (
    input  logic                               sample_clk,
    input  logic                               rst_n,
    input  logic                               bit_valid,
    input  logic                               bit_value,
    input  logic                               frame_end,
    output logic                               frame_valid,
    output logic [DATA_BITS:0]                 frame_bits,
    output logic [$clog2(DATA_BITS+3)-1:0]     frame_count
);
    import pwc_pkg::*;

    localparam int CW = $clog2(DATA_BITS + 3);

    // count saturates one past a full frame.
    localparam logic [CW-1:0] CNT_SAT  = CW'(DATA_BITS + 2);
    localparam logic [CW-1:0] LAST_IDX = CW'(DATA_BITS);

    logic [DATA_BITS:0] shift_q;
    logic [CW-1:0]      bit_cnt;
    logic               hand_over;

    assign hand_over = frame_end && (bit_cnt != '0);

    always_ff @(posedge sample_clk) begin
        if (!rst_n) begin
            shift_q     <= '0;
            bit_cnt     <= '0;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (frame_end) begin
                frame_valid <= hand_over;
                shift_q     <= '0;
                bit_cnt     <= '0;
            end else if (bit_valid) begin
                // lsb first, extra bits only bump the count.
                if (bit_cnt <= LAST_IDX) begin
                    shift_q[bit_cnt] <= bit_value;
                end
                if (bit_cnt != CNT_SAT) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sample_clk) begin
        if (hand_over) begin
            frame_bits  <= shift_q;
            frame_count <= bit_cnt;
        end
    end

endmodule

/* hw/pwc_frame_checker.sv */
`timescale 1ns/1ps

module pwc_frame_checker #(
    parameter int DATA_BITS = pwc_pkg::DEF_DATA_BITS
) (
    input  logic                           sample_clk,
    input  logic                           rst_n,
    input  logic                           frame_valid,
    input  logic [DATA_BITS:0]             frame_bits,
    input  logic [$clog2(DATA_BITS+3)-1:0] frame_count,
    output logic                           rx_valid,
    output logic [DATA_BITS-1:0]           rx_data,
    output logic                           rx_error,
    output logic                           err_parity,
    output logic                           err_length
);
    import pwc_pkg::*;

    localparam int            CW        = $clog2(DATA_BITS + 3);
    localparam logic [CW-1:0] FRAME_LEN = CW'(DATA_BITS + 1);

    logic len_bad;
    logic par_bad;

    assign len_bad = frame_count != FRAME_LEN;

    // even parity over data and parity bit.
    assign par_bad = !len_bad && (^frame_bits);

    always_ff @(posedge sample_clk) begin
        if (!rst_n) begin
            rx_valid   <= 1'b0;
            rx_error   <= 1'b0;
            err_parity <= 1'b0;
            err_length <= 1'b0;
        end else begin
            rx_valid   <= frame_valid && !len_bad && !par_bad;
            rx_error   <= frame_valid && (len_bad || par_bad);
            err_parity <= frame_valid && par_bad;
            err_length <= frame_valid && len_bad;
        end
    end

    always_ff @(posedge sample_clk) begin
        if (frame_valid) begin
            rx_data <= frame_bits[DATA_BITS-1:0];
        end
    end

endmodule

/* hw/pwc_rx_top.sv */
`timescale 1ns/1ps

module pwc_rx_top #(
    parameter int CNT_WIDTH  = pwc_pkg::DEF_CNT_WIDTH,
    parameter int IDLE_LIMIT = pwc_pkg::DEF_IDLE_LIMIT,
    parameter int DATA_BITS  = pwc_pkg::DEF_DATA_BITS
) (
    input  logic                 sample_clk,
    input  logic                 rst_n,
    input  logic                 rx_line,
    output logic                 rx_valid,
    output logic [DATA_BITS-1:0] rx_data,
    output logic                 rx_error,
    output logic                 err_parity,
    output logic                 err_length
);
    import pwc_pkg::*;

    localparam int FC_W = $clog2(DATA_BITS + 3);

    logic               bit_valid;
    logic               bit_value;
    logic               frame_end;
    logic               frame_valid;
    logic [DATA_BITS:0] frame_bits;
    logic [FC_W-1:0]    frame_count;

    pwc_bit_decoder #(
        .CNT_WIDTH  (CNT_WIDTH),
        .IDLE_LIMIT (IDLE_LIMIT)
    ) decoder_i (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .rx_line    (rx_line),
        .bit_valid  (bit_valid),
        .bit_value  (bit_value),
        .frame_end  (frame_end)
    );

    pwc_frame_assembler #(
        .DATA_BITS (DATA_BITS)
    ) assembler_i (
        .sample_clk  (sample_clk),
        .rst_n       (rst_n),
        .bit_valid   (bit_valid),
        .bit_value   (bit_value),
        .frame_end   (frame_end),
        .frame_valid (frame_valid),
        .frame_bits  (frame_bits),
        .frame_count (frame_count)
    );

    pwc_frame_checker #(
        .DATA_BITS (DATA_BITS)
    ) checker_i (
        .sample_clk  (sample_clk),
        .rst_n       (rst_n),
        .frame_valid (frame_valid),
        .frame_bits  (frame_bits),
        .frame_count (frame_count),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .rx_error    (rx_error),
        .err_parity  (err_parity),
        .err_length  (err_length)
    );

endmodule

/* tests/pwc_rx_checker.sv */
`timescale 1ns/1ps

module pwc_rx_checker (
    input logic                sample_clk,
    input logic                rst_n,
    input logic                bit_valid,
    input logic                frame_end,
    input logic                frame_valid,
    input logic                rx_valid,
    input logic                rx_error,
    input logic                err_parity,
    input logic                err_length,
    input pwc_pkg::dec_state_t dec_state
);
    import pwc_pkg::*;

    int fail_cnt = 0;

    // one result kind per frame.
    a_one_result: assert property (@(posedge sample_clk) !(rx_valid && rx_error))
        else begin
            $error("rx_valid and rx_error high together");
            fail_cnt++;
        end

    a_bit_or_end: assert property (@(posedge sample_clk) !(bit_valid && frame_end))
        else begin
            $error("bit_valid and frame_end high together");
            fail_cnt++;
        end

    a_flags: assert property (@(posedge sample_clk) (err_parity || err_length) |-> rx_error)
        else begin
            $error("error flag without rx_error");
            fail_cnt++;
        end

    // everything quiet one cycle into reset.
    a_reset: assert property (@(posedge sample_clk) !rst_n |=>
            !(bit_valid || frame_end || frame_valid || rx_valid || rx_error ||
              err_parity || err_length) && dec_state == ST_IDLE)
        else begin
            $error("strobe or decoder state not cleared by reset");
            fail_cnt++;
        end

endmodule

bind pwc_rx_top pwc_rx_checker chk_i (
    .sample_clk  (sample_clk),
    .rst_n       (rst_n),
    .bit_valid   (bit_valid),
    .frame_end   (frame_end),
    .frame_valid (frame_valid),
    .rx_valid    (rx_valid),
    .rx_error    (rx_error),
    .err_parity  (err_parity),
    .err_length  (err_length),
    .dec_state   (decoder_i.state)
);

/* tests/pwc_rx_tb.sv */
`timescale 1ns/1ps

module pwc_rx_tb;
    import pwc_pkg::*;

    localparam int DATA_BITS  = DEF_DATA_BITS;
    localparam int IDLE_LIMIT = DEF_IDLE_LIMIT;
    localparam int MAX_SYM    = DATA_BITS + 4;
    localparam int N_RANDOM   = 40;
    localparam int N_PARITY   = 4;
    localparam int N_LENGTH   = 2;
    localparam int N_TIE      = 6;
    // the reset test sends a partial and a full frame.
    localparam int N_FRAMES   = N_RANDOM + N_PARITY + 2 * N_LENGTH + N_TIE + 2;

    typedef struct packed {
        logic                 ok;
        logic                 err;
        logic                 par;
        logic                 len;
        logic [DATA_BITS-1:0] data;
    } result_t;

    logic                 sample_clk;
    logic                 rst_n;
    logic                 rx_line;
    logic                 rx_valid;
    logic [DATA_BITS-1:0] rx_data;
    logic                 rx_error;
    logic                 err_parity;
    logic                 err_length;

    result_t exp_q[$];
    result_t exp_r;
    result_t got_r;
    int      err_cnt     = 0;
    int      errs_before = 0;
    int      test_num    = 0;
    int      pass_tests  = 0;
    int      fail_tests  = 0;

    pwc_rx_top #(
        .CNT_WIDTH  (DEF_CNT_WIDTH),
        .IDLE_LIMIT (IDLE_LIMIT),
        .DATA_BITS  (DATA_BITS)
    ) dut_i (
        .sample_clk (sample_clk),
        .rst_n      (rst_n),
        .rx_line    (rx_line),
        .rx_valid   (rx_valid),
        .rx_data    (rx_data),
        .rx_error   (rx_error),
        .err_parity (err_parity),
        .err_length (err_length)
    );

    initial begin
        sample_clk = 1'b0;
        forever #5 sample_clk = ~sample_clk;
    end

    // tie symbols decode as 1.
    function automatic result_t expect_result(input logic [MAX_SYM-1:0] sent,
                                              input logic [MAX_SYM-1:0] ties, input int n);
        result_t            r;
        logic [MAX_SYM-1:0] bits;
        bits = '0;
        r    = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = ties[i] ? 1'b1 : sent[i];
        end
        if (n != DATA_BITS + 1) begin
            r.err = 1'b1;
            r.len = 1'b1;
        end else if (^bits[DATA_BITS:0]) begin
            r.err = 1'b1;
            r.par = 1'b1;
        end else begin
            r.ok   = 1'b1;
            r.data = bits[DATA_BITS-1:0];
        end
        return r;
    endfunction

    function automatic logic [MAX_SYM-1:0] make_frame(input logic [DATA_BITS-1:0] data,
                                                      input logic flip);
        return MAX_SYM'({(^data) ^ flip, data});
    endfunction

    function automatic int total_errors();
        return err_cnt + dut_i.chk_i.fail_cnt;
    endfunction

    task automatic drive_level(input logic level, input int cycles);
        repeat (cycles) begin
            @(posedge sample_clk);
            rx_line <= level;
        end
    endtask

    task automatic pick_symbol(input logic b, input logic tie, output int lo, output int hi);
        if (tie) begin
            lo = $urandom_range(8, 3);
            hi = lo;
        end else if (b) begin
            lo = $urandom_range(4, 2);
            hi = $urandom_range(9, 6);
        end else begin
            lo = $urandom_range(9, 6);
            hi = $urandom_range(4, 2);
        end
    endtask

    task automatic send_frame(input logic [MAX_SYM-1:0] bits, input logic [MAX_SYM-1:0] ties,
                              input int n);
        int lows[MAX_SYM];
        int highs[MAX_SYM];
        for (int i = 0; i < n; i++) begin
            pick_symbol(bits[i], ties[i], lows[i], highs[i]);
        end
        exp_q.push_back(expect_result(bits, ties, n));
        for (int i = 0; i < n; i++) begin
            drive_level(1'b0, lows[i]);
            drive_level(1'b1, highs[i]);
        end
        // trailing low pulse settles the last bit.
        drive_level(1'b0, 3);
        drive_level(1'b1, IDLE_LIMIT + 4);
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0) begin
            @(posedge sample_clk);
        end
        repeat (IDLE_LIMIT) @(posedge sample_clk);
        test_num++;
        if (total_errors() == errs_before) begin
            pass_tests++;
            $display("test %0d %s: PASS", test_num, name);
        end else begin
            fail_tests++;
            $display("test %0d %s: FAIL", test_num, name);
        end
        errs_before = total_errors();
    endtask

    // outputs settle after the rising edge.
    always @(negedge sample_clk) begin
        if (rx_valid || rx_error) begin
            assert (exp_q.size() != 0) else begin
                $display("result pulse at %0t arrived with no frame in flight", $time);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp_r      = exp_q.pop_front();
                got_r.ok   = rx_valid;
                got_r.err  = rx_error;
                got_r.par  = err_parity;
                got_r.len  = err_length;
                got_r.data = rx_valid ? rx_data : '0;
                assert (got_r == exp_r) else begin
                    $display("[ERROR] %0t: got ok%b err%b par%b len%b data %h, ", $time,
                             got_r.ok, got_r.err, got_r.par, got_r.len, got_r.data,
                             "expected ok%b err%b par%b len%b data %h",
                             exp_r.ok, exp_r.err, exp_r.par, exp_r.len, exp_r.data);
                    err_cnt++;
                end
            end
        end
    end

    initial begin
        repeat (N_FRAMES * 400 + 1000) @(posedge sample_clk);
        $display("watchdog expired, %0d expected results never arrived", exp_q.size());
        $display("tests failed");
        $finish;
    end

    initial begin
        logic [DATA_BITS-1:0] data;
        int                   lo;
        int                   hi;
        void'($urandom(11807));
        rst_n   = 1'b0;
        rx_line = 1'b1;
        repeat (8) @(posedge sample_clk);
        rst_n <= 1'b1;
        drive_level(1'b1, 5);

        repeat (N_RANDOM) send_frame(make_frame(DATA_BITS'($urandom), 1'b0), '0, DATA_BITS + 1);
        finish_test("random frames");

        repeat (N_PARITY) send_frame(make_frame(DATA_BITS'($urandom), 1'b1), '0, DATA_BITS + 1);
        finish_test("inverted parity");

        repeat (N_LENGTH) begin
            send_frame(MAX_SYM'($urandom), '0, DATA_BITS - 2);
            send_frame(MAX_SYM'($urandom), '0, DATA_BITS + 3);
        end
        finish_test("short and long frames");

        // some 1 bits sent with equal phases.
        repeat (N_TIE) begin
            data = DATA_BITS'($urandom);
            send_frame(make_frame(data, 1'b0), MAX_SYM'(data & DATA_BITS'($urandom)),
                       DATA_BITS + 1);
        end
        finish_test("tie symbols");

        for (int i = 0; i < 4; i++) begin
            pick_symbol(1'($urandom), 1'b0, lo, hi);
            drive_level(1'b0, lo);
            drive_level(1'b1, hi);
        end
        drive_level(1'b0, 2);
        @(posedge sample_clk);
        rst_n   <= 1'b0;
        rx_line <= 1'b1;
        repeat (8) @(posedge sample_clk);
        rst_n <= 1'b1;
        drive_level(1'b1, 5);
        send_frame(make_frame(DATA_BITS'($urandom), 1'b0), '0, DATA_BITS + 1);
        finish_test("reset mid frame");

        drive_level(1'b1, IDLE_LIMIT * 4);
        finish_test("idle line");

        $display("summary: %0d passed, %0d failed", pass_tests, fail_tests);
        if (fail_tests == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
hw/pwc_pkg.sv
hw/pwc_bit_decoder.sv
hw/pwc_frame_assembler.sv
hw/pwc_frame_checker.sv
hw/pwc_rx_top.sv
tests/pwc_rx_checker.sv
tests/pwc_rx_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

rm -rf obj_dir
if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module pwc_rx_tb -f compile.f; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vpwc_rx_tb +verilator+error+limit+1000 > "$log" 2>&1
sim_status=$?
cat "$log"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "all tests passed" "$log"; then
    echo "PASS"
    exit 0
fi

echo "FAIL"
exit 1
